// ==== filelist.f ====
hdl/fb_write_pkg.sv
hdl/fb_fifo.sv
hdl/transfer_tracker.sv
hdl/burst_planner.sv
hdl/beat_packer.sv
hdl/fb_writer_top.sv
verification/fb_writer_checker.sv
verification/fb_writer_tb.sv

// ==== hdl/beat_packer.sv ====
`timescale 1ns/1ps
// Write data never leads its address, since lengths enter the FIFO only on AW handshakes
module beat_packer #(
    parameter int DATA_WIDTH = fb_write_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     len_empty,
    input  fb_write_pkg::burst_len_t len_data,
    input  logic                     data_empty,
    input  logic [DATA_WIDTH-1:0]    data_word,
    input  logic                     wready,
    output logic                     len_pop,
    output logic                     data_pop,
    output logic                     wvalid,
    output logic [DATA_WIDTH-1:0]    wdata,
    output logic                     wlast
);
    fb_write_pkg::burst_len_t beats_left;
    fb_write_pkg::burst_len_t cur_left;
    logic                     in_burst;
    logic                     have_len;
    logic                     w_fire;

    // Between bursts the FIFO head supplies the count, so a new burst starts without a gap
    assign cur_left = in_burst ? beats_left : len_data;
    assign have_len = in_burst || !len_empty;

    assign wvalid   = have_len && !data_empty;
    assign wdata    = data_word;
    assign wlast    = (cur_left == '0);
    assign w_fire   = wvalid && wready;
    assign data_pop = w_fire;

    // The length leaves its FIFO with the first beat of the burst
    assign len_pop  = w_fire && !in_burst;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_burst   <= 1'b0;
            beats_left <= '0;
        end
        else if (w_fire)
        begin
            if (wlast)
            begin
                in_burst <= 1'b0;
            end
            else
            begin
                in_burst   <= 1'b1;
                beats_left <= cur_left - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/burst_planner.sv ====
`timescale 1ns/1ps
// Start address must be word aligned and the byte count a nonzero multiple of the word size
module burst_planner #(
    parameter int ADDR_WIDTH      = fb_write_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH      = fb_write_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_BURST_BEATS = 16
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [ADDR_WIDTH-1:0]    start_addr,
    input  logic [ADDR_WIDTH-1:0]    start_bytes,
    input  logic                     awready,
    input  logic                     len_full,
    output logic                     awvalid,
    output logic [ADDR_WIDTH-1:0]    awaddr,
    output fb_write_pkg::burst_len_t awlen,
    output logic                     len_push,
    output fb_write_pkg::burst_len_t len_data,
    output logic                     aw_fire,
    output logic                     plan_done
);
    localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
    localparam int SIZE_LG        = $clog2(BYTES_PER_WORD);
    localparam int PAGE_LG        = $clog2(fb_write_pkg::AXI_PAGE_BYTES);

    logic [ADDR_WIDTH-1:0] cur_addr;
    logic [ADDR_WIDTH-1:0] cur_words;
    logic [ADDR_WIDTH-1:0] page_left;
    logic [ADDR_WIDTH-1:0] page_words;
    logic [ADDR_WIDTH-1:0] beats;
    logic                  pending;

    // Words that still fit before the next 4 KB boundary
    assign page_left  = ADDR_WIDTH'(fb_write_pkg::AXI_PAGE_BYTES)
                      - ADDR_WIDTH'(cur_addr[PAGE_LG-1:0]);
    assign page_words = page_left >> SIZE_LG;

    // Smallest of the length limit, the words remaining and the page limit
    always_comb
    begin
        beats = ADDR_WIDTH'(MAX_BURST_BEATS);
        if (cur_words < beats)
        begin
            beats = cur_words;
        end
        if (page_words < beats)
        begin
            beats = page_words;
        end
    end

    assign awaddr    = cur_addr;
    assign awlen     = fb_write_pkg::burst_len_t'(beats - 1'b1);
    assign aw_fire   = awvalid && awready;
    assign len_push  = aw_fire;
    assign len_data  = awlen;
    assign plan_done = aw_fire && (cur_words == beats);

    // Request registers change only on a handshake, so AW stays stable while it waits
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            awvalid   <= 1'b0;
            pending   <= 1'b0;
            cur_addr  <= '0;
            cur_words <= '0;
        end
        else if (start)
        begin
            // The length FIFO has drained by the time a new transfer is accepted
            cur_addr  <= start_addr;
            cur_words <= start_bytes >> SIZE_LG;
            awvalid   <= 1'b1;
            pending   <= 1'b0;
        end
        else if (aw_fire)
        begin
            cur_addr  <= cur_addr + (beats << SIZE_LG);
            cur_words <= cur_words - beats;
            awvalid   <= 1'b0;
            pending   <= (cur_words != beats);
        end
        else if (pending && !len_full)
        begin
            // The push from the last handshake is visible now, so full is exact
            awvalid <= 1'b1;
            pending <= 1'b0;
        end
    end

endmodule

// ==== hdl/fb_fifo.sv ====
`timescale 1ns/1ps
// Register-array FIFO with a look-through head, a push while full or a pop while empty is dropped
module fb_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge aclk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so that DEPTH need not be a power of two
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/fb_write_pkg.sv ====
// Shared AXI constants and default widths; default sizes assume 32-bit addresses and 32-bit words
package fb_write_pkg;

    // Default memory address width
    localparam int DEFAULT_ADDR_WIDTH = 32;

    // Default memory data width, one pixel word per beat
    localparam int DEFAULT_DATA_WIDTH = 32;

    // Width of the AXI burst-length field
    localparam int AXI_LEN_WIDTH = 8;

    // AXI length encoding, which holds the beat count minus one
    typedef logic [AXI_LEN_WIDTH-1:0] burst_len_t;

    // Incrementing burst code for awburst
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // OKAY code on bresp
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // No burst may cross a boundary of this many bytes
    localparam int AXI_PAGE_BYTES = 4096;

endpackage

// ==== hdl/fb_writer_top.sv ====
`timescale 1ns/1ps
// Single AXI4 write master with ID 0, full-word strobes only and no read channels
module fb_writer_top #(
    parameter int ADDR_WIDTH      = fb_write_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH      = fb_write_pkg::DEFAULT_DATA_WIDTH,
    parameter int MAX_BURST_BEATS = 16,
    parameter int LEN_FIFO_DEPTH  = 4,
    parameter int DATA_FIFO_DEPTH = 4
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     tstart,
    input  logic [ADDR_WIDTH-1:0]    taddr,
    input  logic [ADDR_WIDTH-1:0]    tbytes,
    input  logic                     s_valid,
    input  logic [DATA_WIDTH-1:0]    s_data,
    input  logic                     awready,
    input  logic                     wready,
    input  logic                     bvalid,
    input  logic [1:0]               bresp,
    output logic                     s_ready,
    output logic                     awvalid,
    output logic [ADDR_WIDTH-1:0]    awaddr,
    output fb_write_pkg::burst_len_t awlen,
    output logic [2:0]               awsize,
    output logic [1:0]               awburst,
    output logic                     wvalid,
    output logic [DATA_WIDTH-1:0]    wdata,
    output logic [DATA_WIDTH/8-1:0]  wstrb,
    output logic                     wlast,
    output logic                     bready,
    output logic                     busy,
    output logic                     tdone,
    output logic                     resp_error
);
    logic                     start;
    logic [ADDR_WIDTH-1:0]    start_addr;
    logic [ADDR_WIDTH-1:0]    start_bytes;
    logic                     aw_fire;
    logic                     plan_done;
    logic                     len_push;
    fb_write_pkg::burst_len_t len_push_data;
    logic                     len_pop;
    fb_write_pkg::burst_len_t len_head;
    logic                     len_empty;
    logic                     len_full;
    logic                     data_pop;
    logic [DATA_WIDTH-1:0]    data_word;
    logic                     data_empty;
    logic                     data_full;

    assign awsize  = 3'($clog2(DATA_WIDTH / 8));
    assign awburst = fb_write_pkg::AXI_BURST_INCR;
    assign wstrb   = {(DATA_WIDTH / 8){1'b1}};
    assign s_ready = !data_full;

    transfer_tracker #(.ADDR_WIDTH(ADDR_WIDTH)) u_transfer_tracker (
        .aclk(aclk), .rst_n(rst_n), .tstart(tstart), .taddr(taddr), .tbytes(tbytes),
        .aw_fire(aw_fire), .plan_done(plan_done), .bvalid(bvalid), .bresp(bresp),
        .start(start), .start_addr(start_addr), .start_bytes(start_bytes), .busy(busy),
        .bready(bready), .tdone(tdone), .resp_error(resp_error)
    );

    burst_planner #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .MAX_BURST_BEATS(MAX_BURST_BEATS)
    ) u_burst_planner (
        .aclk(aclk), .rst_n(rst_n), .start(start), .start_addr(start_addr),
        .start_bytes(start_bytes), .awready(awready), .len_full(len_full),
        .awvalid(awvalid), .awaddr(awaddr), .awlen(awlen), .len_push(len_push),
        .len_data(len_push_data), .aw_fire(aw_fire), .plan_done(plan_done)
    );

    // Lengths of bursts whose address is out but whose data has not started
    fb_fifo #(.payload_t(fb_write_pkg::burst_len_t), .DEPTH(LEN_FIFO_DEPTH)) u_len_fifo (
        .aclk(aclk), .rst_n(rst_n), .push(len_push), .push_data(len_push_data),
        .pop(len_pop), .pop_data(len_head), .empty(len_empty), .full(len_full)
    );

    fb_fifo #(.payload_t(logic [DATA_WIDTH-1:0]), .DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
        .aclk(aclk), .rst_n(rst_n), .push(s_valid), .push_data(s_data),
        .pop(data_pop), .pop_data(data_word), .empty(data_empty), .full(data_full)
    );

    beat_packer #(.DATA_WIDTH(DATA_WIDTH)) u_beat_packer (
        .aclk(aclk), .rst_n(rst_n), .len_empty(len_empty), .len_data(len_head),
        .data_empty(data_empty), .data_word(data_word), .wready(wready),
        .len_pop(len_pop), .data_pop(data_pop), .wvalid(wvalid), .wdata(wdata),
        .wlast(wlast)
    );

endmodule

// ==== hdl/transfer_tracker.sv ====
`timescale 1ns/1ps
// One transfer at a time, a tstart seen while busy is dropped and bready is always held high
module transfer_tracker #(
    parameter int ADDR_WIDTH = fb_write_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  tstart,
    input  logic [ADDR_WIDTH-1:0] taddr,
    input  logic [ADDR_WIDTH-1:0] tbytes,
    input  logic                  aw_fire,
    input  logic                  plan_done,
    input  logic                  bvalid,
    input  logic [1:0]            bresp,
    output logic                  start,
    output logic [ADDR_WIDTH-1:0] start_addr,
    output logic [ADDR_WIDTH-1:0] start_bytes,
    output logic                  busy,
    output logic                  bready,
    output logic                  tdone,
    output logic                  resp_error
);
    logic                  b_fire;
    logic                  plan_seen;
    logic [ADDR_WIDTH-1:0] outstanding;
    logic [ADDR_WIDTH-1:0] outstanding_next;

    assign start       = tstart && !busy;
    assign start_addr  = taddr;
    assign start_bytes = tbytes;
    assign bready      = 1'b1;
    assign b_fire      = bvalid && bready;

    // Bursts issued minus responses collected
    assign outstanding_next = outstanding + ADDR_WIDTH'(aw_fire) - ADDR_WIDTH'(b_fire);

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy        <= 1'b0;
            plan_seen   <= 1'b0;
            outstanding <= '0;
            tdone       <= 1'b0;
            resp_error  <= 1'b0;
        end
        else
        begin
            // The final burst always answers after plan_done, so the last event is a B beat
            tdone <= busy && b_fire && plan_seen && (outstanding_next == '0);

            if (start)
            begin
                busy        <= 1'b1;
                plan_seen   <= 1'b0;
                outstanding <= '0;
                resp_error  <= 1'b0;
            end
            else
            begin
                if (tdone)
                begin
                    busy <= 1'b0;
                end
                if (plan_done)
                begin
                    plan_seen <= 1'b1;
                end
                if (busy)
                begin
                    outstanding <= outstanding_next;
                end
                if (busy && b_fire && (bresp != fb_write_pkg::AXI_RESP_OKAY))
                begin
                    resp_error <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verification/fb_writer_checker.sv ====
// AXI write protocol and completion assertions for fb_writer_top, bound to every instance of it
`timescale 1ns/1ps
module fb_writer_checker #(
    parameter int ADDR_WIDTH = fb_write_pkg::DEFAULT_ADDR_WIDTH,
    parameter int DATA_WIDTH = fb_write_pkg::DEFAULT_DATA_WIDTH
) (
    input logic                     aclk,
    input logic                     rst_n,
    input logic                     awvalid,
    input logic                     awready,
    input logic [ADDR_WIDTH-1:0]    awaddr,
    input fb_write_pkg::burst_len_t awlen,
    input logic                     wvalid,
    input logic                     wready,
    input logic [DATA_WIDTH-1:0]    wdata,
    input logic                     wlast,
    input logic                     tdone,
    input logic                     busy
);
    int fail_count = 0;

    // An address request waits unchanged for awready
    aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else
        begin
            fail_count++;
            $error("AW request dropped or changed before awready");
        end

    // A write beat waits unchanged for wready
    w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else
        begin
            fail_count++;
            $error("W beat dropped or changed before wready");
        end

    done_single: assert property (@(posedge aclk) disable iff (!rst_n)
        tdone |=> !tdone)
        else
        begin
            fail_count++;
            $error("tdone held high for two cycles");
        end

    // Completion only ends a running transfer, and busy drops right after it
    done_in_busy: assert property (@(posedge aclk) disable iff (!rst_n)
        tdone |-> busy)
        else
        begin
            fail_count++;
            $error("tdone raised while not busy");
        end

    busy_clears: assert property (@(posedge aclk) disable iff (!rst_n)
        tdone |=> !busy)
        else
        begin
            fail_count++;
            $error("busy still high after tdone");
        end

endmodule

bind fb_writer_top fb_writer_checker #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
) u_fb_writer_checker (.*);

// ==== verification/fb_writer_tb.sv ====
// Runs the DUT at 32-bit widths and 16-beat bursts; the memory model serves one transfer at a time
`timescale 1ns/1ps
module fb_writer_tb;
    localparam int         MAX_BEATS   = 16;
    localparam int         NUM_ROWS    = 6;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct {
        logic [31:0] addr;
        logic [31:0] bytes;
        bit          aw_stall;
        bit          w_stall;
        int          err_burst;
        bit          exp_error;
    } row_t;

    // Address, bytes, AW stall, W stall, burst answered with an error, expected resp_error
    row_t rows [NUM_ROWS] = '{
        '{32'h0000_1000, 32'd64,  1'b0, 1'b0, -1, 1'b0},
        '{32'h0000_1ff0, 32'd40,  1'b0, 1'b0, -1, 1'b0},
        '{32'h0000_2000, 32'd400, 1'b1, 1'b1, -1, 1'b0},
        '{32'h0000_3fc0, 32'd256, 1'b1, 1'b1,  2, 1'b1},
        '{32'h0000_5004, 32'd4,   1'b0, 1'b1,  0, 1'b1},
        '{32'h0000_6f00, 32'd300, 1'b1, 1'b0, -1, 1'b0}
    };

    logic                     aclk;
    logic                     rst_n;
    logic                     tstart;
    logic [31:0]              taddr;
    logic [31:0]              tbytes;
    logic                     s_valid;
    logic [31:0]              s_data;
    logic                     awready;
    logic                     wready;
    logic                     bvalid;
    logic [1:0]               bresp;
    logic                     s_ready;
    logic                     awvalid;
    logic [31:0]              awaddr;
    fb_write_pkg::burst_len_t awlen;
    logic [2:0]               awsize;
    logic [1:0]               awburst;
    logic                     wvalid;
    logic [31:0]              wdata;
    logic [3:0]               wstrb;
    logic                     wlast;
    logic                     bready;
    logic                     busy;
    logic                     tdone;
    logic                     resp_error;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] exp_words [$];
    logic [31:0] aw_addr_q [$];
    int          aw_len_q [$];
    bit          aw_err_q [$];
    logic [1:0]  b_q [$];
    logic [31:0] next_aw_addr;
    bit          aw_stall;
    bit          w_stall;
    bit          done_error;
    int          err_burst;
    int          burst_idx;
    int          w_beat;
    int          beats_seen;
    int          page_end;
    int          tdone_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    fb_writer_top #(.MAX_BURST_BEATS(MAX_BEATS)) u_fb_writer_top (.*);

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout: no completion within %0d clock cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Burst count from the length limit, the words left and the 4 KB page room
    function automatic int expected_bursts(input logic [31:0] addr, input int words);
        int n;
        int room;
        int beats;
        n = 0;
        while (words > 0)
        begin
            room  = (fb_write_pkg::AXI_PAGE_BYTES - int'(addr[11:0])) / 4;
            beats = (words < MAX_BEATS) ? words : MAX_BEATS;
            if (room < beats)
            begin
                beats = room;
            end
            addr  = addr + 32'(beats * 4);
            words = words - beats;
            n++;
        end
        return n;
    endfunction

    // Memory model samples at the falling edge and drives its ready and B signals after the rise
    always
    begin
        @(negedge aclk);
        if (rst_n)
        begin
            if (awvalid && awready)
            begin
                page_end = int'(awaddr[11:0]) + (int'(awlen) + 1) * 4;
                expect_equal("AW address", awaddr, next_aw_addr);
                expect_equal("burst within length limit", int'(awlen) < MAX_BEATS, 1'b1);
                expect_equal("burst within 4 KB page", page_end <= fb_write_pkg::AXI_PAGE_BYTES,
                             1'b1);
                expect_equal("awsize", awsize, 3'd2);
                expect_equal("awburst", awburst, fb_write_pkg::AXI_BURST_INCR);
                aw_addr_q.push_back(awaddr);
                aw_len_q.push_back(int'(awlen));
                aw_err_q.push_back(burst_idx == err_burst);
                next_aw_addr = awaddr + 32'((int'(awlen) + 1) * 4);
                burst_idx++;
            end
            if (wvalid && wready)
            begin
                if (aw_len_q.size() == 0)
                begin
                    errors++;
                    $display("Write beat at %0t ns arrived before its burst address", $time);
                end
                else
                begin
                    mem[aw_addr_q[0] + 32'(w_beat * 4)] = wdata;
                    expect_equal("wlast", wlast, w_beat == aw_len_q[0]);
                    expect_equal("wstrb", wstrb, 4'hf);
                    beats_seen++;
                    if (w_beat == aw_len_q[0])
                    begin
                        b_q.push_back(aw_err_q[0] ? RESP_SLVERR : fb_write_pkg::AXI_RESP_OKAY);
                        void'(aw_addr_q.pop_front());
                        void'(aw_len_q.pop_front());
                        void'(aw_err_q.pop_front());
                        w_beat = 0;
                    end
                    else
                    begin
                        w_beat++;
                    end
                end
            end
            if (bvalid)
            begin
                expect_equal("bready", bready, 1'b1);
                if (bready)
                begin
                    void'(b_q.pop_front());
                end
            end
            if (tdone)
            begin
                tdone_count++;
                done_error = resp_error;
            end
        end
        @(posedge aclk);
        #1;
        awready = aw_stall ? ($urandom_range(3) != 0) : 1'b1;
        wready  = w_stall ? ($urandom_range(3) != 0) : 1'b1;
        bvalid  = (b_q.size() != 0);
        bresp   = (b_q.size() != 0) ? b_q[0] : fb_write_pkg::AXI_RESP_OKAY;
    end

    // The second cycle of tstart carries a different command and must be ignored
    task automatic start_transfer(input logic [31:0] addr, input logic [31:0] bytes);
        @(posedge aclk);
        #1;
        tstart = 1'b1;
        taddr  = addr;
        tbytes = bytes;
        @(posedge aclk);
        #1;
        taddr  = 32'h0008_0000;
        tbytes = 32'd64;
        @(negedge aclk);
        expect_equal("busy during a transfer", busy, 1'b1);
        @(posedge aclk);
        #1;
        tstart = 1'b0;
    endtask

    task automatic send_words();
        int i;
        i = 0;
        while (i < exp_words.size())
        begin
            s_valid = 1'b1;
            s_data  = exp_words[i];
            @(negedge aclk);
            if (s_ready)
            begin
                i++;
            end
            @(posedge aclk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    task automatic wait_for_done(input int count_before);
        while (tdone_count == count_before)
        begin
            @(posedge aclk);
        end
        // A few more cycles expose any extra burst or extra tdone
        repeat (5) @(posedge aclk);
        #1;
    endtask

    initial
    begin
        int          nwords;
        int          row_errors;
        int          done_before;
        logic [31:0] a;
        void'($urandom(32'h4f77));
        rst_n     = 1'b0;
        tstart    = 1'b0;
        taddr     = '0;
        tbytes    = '0;
        s_valid   = 1'b0;
        s_data    = '0;
        awready   = 1'b1;
        wready    = 1'b1;
        bvalid    = 1'b0;
        bresp     = fb_write_pkg::AXI_RESP_OKAY;
        aw_stall  = 1'b0;
        w_stall   = 1'b0;
        err_burst = -1;
        burst_idx = 0;
        w_beat    = 0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            cycle_limit += 4 * int'(rows[r].bytes / 4) + 50;
        end
        repeat (4) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        @(negedge aclk);
        expect_equal("awvalid after reset", awvalid, 1'b0);
        expect_equal("wvalid after reset", wvalid, 1'b0);
        expect_equal("tdone after reset", tdone, 1'b0);
        expect_equal("busy after reset", busy, 1'b0);
        expect_equal("s_ready after reset", s_ready, 1'b1);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row_errors   = errors;
            done_before  = tdone_count;
            nwords       = int'(rows[r].bytes / 4);
            aw_stall     = rows[r].aw_stall;
            w_stall      = rows[r].w_stall;
            err_burst    = rows[r].err_burst;
            burst_idx    = 0;
            beats_seen   = 0;
            next_aw_addr = rows[r].addr;
            exp_words.delete();
            for (int i = 0; i < nwords; i++)
            begin
                exp_words.push_back($urandom());
            end
            start_transfer(rows[r].addr, rows[r].bytes);
            send_words();
            wait_for_done(done_before);

            expect_equal("tdone pulses", tdone_count, done_before + 1);
            expect_equal("bursts issued", burst_idx, expected_bursts(rows[r].addr, nwords));
            expect_equal("beats written", beats_seen, nwords);
            expect_equal("resp_error", done_error, rows[r].exp_error);
            expect_equal("busy after tdone", busy, 1'b0);
            for (int i = 0; i < nwords; i++)
            begin
                a = rows[r].addr + 32'(i * 4);
                expect_equal("memory word", mem.exists(a) ? mem[a] : 32'hx, exp_words[i]);
            end
            $display("Test %0d at %h with %0d words: %s", r, rows[r].addr, nwords,
                     (errors == row_errors) ? "ok" : "mismatches");
        end

        // Protocol assertions in the bound checker count toward the result
        errors += u_fb_writer_top.u_fb_writer_checker.fail_count;
        $display("%0d tests run, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
